//--- rtl/coreplex_pkg.sv
/*
 * Address map, bus widths and word types shared by the coreplex fabric
 */
`default_nettype none

package coreplex_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------

    // Byte lanes per bus word
    localparam int NB_COL    = 4;
    localparam int COL_WIDTH = 8;

    // Full bus word, also used for addresses
    typedef logic [NB_COL*COL_WIDTH-1:0] word_t;

    // One enable bit per byte lane
    typedef logic [NB_COL-1:0] be_t;

    // ----------------------------------------
    // TCM region
    // ----------------------------------------

    // Address bits decoded inside the TCM, 1 KiB
    localparam int TCM_AWIDTH = 10;

    // Word count behind the TCM index
    localparam int TCM_DEPTH = 2 ** (TCM_AWIDTH - 2);

    // Word index, taken from addr[TCM_AWIDTH-1:2]
    typedef logic [TCM_AWIDTH-3:0] tcm_idx_t;

    localparam word_t TCM_ADDR_BASE = 32'h8000_0000;

    // In-region bits of a TCM address
    localparam word_t TCM_ADDR_MASK = word_t'((64'd1 << TCM_AWIDTH) - 64'd1);

    // ----------------------------------------
    // Data peripheral region
    // ----------------------------------------

    localparam word_t PD_ADDR_BASE = 32'h1000_0000;
    localparam word_t PD_ADDR_MASK = 32'h0fff_ffff;

endpackage : coreplex_pkg

`default_nettype wire

//--- rtl/bus_decoder.sv
/*
 * Address decode into TCM and peripheral selects,
 * CPU-side grant forming and data-port response merge
 */
`default_nettype none

module bus_decoder (
    // Instruction port request
    input  wire logic               instr_req_i,
    input  wire coreplex_pkg::word_t instr_addr_i,

    // Data port request
    input  wire logic               data_req_i,
    input  wire coreplex_pkg::word_t data_addr_i,

    // TCM responses
    input  wire logic               tcm_instr_rvalid_i,
    input  wire coreplex_pkg::word_t tcm_instr_rdata_i,
    input  wire logic               tcm_data_rvalid_i,
    input  wire coreplex_pkg::word_t tcm_data_rdata_i,

    // Peripheral bridge
    input  wire logic               pd_gnt_i,
    input  wire logic               pd_rvalid_i,
    input  wire coreplex_pkg::word_t pd_rdata_i,

    // Target selects
    output logic                    tcm_instr_sel_o,
    output logic                    tcm_data_sel_o,
    output logic                    pd_sel_o,

    // CPU-side responses
    output logic                    instr_gnt_o,
    output logic                    instr_rvalid_o,
    output coreplex_pkg::word_t     instr_rdata_o,
    output logic                    data_gnt_o,
    output logic                    data_rvalid_o,
    output coreplex_pkg::word_t     data_rdata_o
);

    import coreplex_pkg::*;

    // Compare only the bits outside the in-region mask
    function automatic logic in_region(word_t addr, word_t base, word_t mask);
        return (addr & ~mask) == (base & ~mask);
    endfunction

    // ----------------------------------------
    // Region decode
    // ----------------------------------------

    // Instruction side only reaches the TCM
    assign tcm_instr_sel_o = instr_req_i
                           & in_region(instr_addr_i, TCM_ADDR_BASE, TCM_ADDR_MASK);

    assign tcm_data_sel_o  = data_req_i
                           & in_region(data_addr_i, TCM_ADDR_BASE, TCM_ADDR_MASK);

    assign pd_sel_o        = data_req_i
                           & in_region(data_addr_i, PD_ADDR_BASE, PD_ADDR_MASK);

    // ----------------------------------------
    // Grants
    // ----------------------------------------

    // TCM always accepts in the request cycle
    assign instr_gnt_o = tcm_instr_sel_o;

    // Peripheral grant waits for the bus transfer
    // Unmapped address matches nothing and stalls
    assign data_gnt_o  = tcm_data_sel_o | pd_gnt_i;

    // ----------------------------------------
    // Response merge
    // ----------------------------------------

    assign instr_rvalid_o = tcm_instr_rvalid_i;
    assign instr_rdata_o  = tcm_instr_rdata_i & {$bits(word_t){tcm_instr_rvalid_i}};

    // At most one target answers per cycle
    assign data_rvalid_o  = tcm_data_rvalid_i | pd_rvalid_i;
    assign data_rdata_o   = (tcm_data_rdata_i & {$bits(word_t){tcm_data_rvalid_i}})
                          | (pd_rdata_i       & {$bits(word_t){pd_rvalid_i}});

endmodule : bus_decoder

`default_nettype wire

//--- rtl/tcm_ram.sv
/*
 * Dual-port TCM with byte-lane writes on the data port
 * and one-cycle read-valid flags on both ports
 */
`default_nettype none

module tcm_ram (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // Port A, instruction fetch, read only
    input  wire logic                   a_en_i,
    input  wire coreplex_pkg::tcm_idx_t a_idx_i,
    output coreplex_pkg::word_t         a_rdata_o,
    output logic                        a_rvalid_o,

    // Port B, data access
    input  wire logic                   b_en_i,
    input  wire coreplex_pkg::tcm_idx_t b_idx_i,
    input  wire logic                   b_we_i,
    input  wire coreplex_pkg::be_t      b_be_i,
    input  wire coreplex_pkg::word_t    b_wdata_i,
    output coreplex_pkg::word_t         b_rdata_o,
    output logic                        b_rvalid_o
);

    import coreplex_pkg::*;

    word_t mem [TCM_DEPTH];

    // Per-lane write strobe for port B
    be_t b_wstrb;

    // Power-up contents are all zero
    initial begin
        for (int i = 0; i < TCM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    for (genvar lane = 0; lane < NB_COL; lane++) begin : g_wstrb
        assign b_wstrb[lane] = b_en_i & b_we_i & b_be_i[lane];
    end

    // ----------------------------------------
    // Port A read
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (a_en_i) begin
            a_rdata_o <= mem[a_idx_i];
        end
    end

    // ----------------------------------------
    // Port B read and byte write
    // ----------------------------------------

    // Nonblocking read returns the word before the write
    always_ff @(posedge clk) begin
        if (b_en_i) begin
            b_rdata_o <= mem[b_idx_i];
        end
        for (int lane = 0; lane < NB_COL; lane++) begin
            if (b_wstrb[lane]) begin
                mem[b_idx_i][lane*COL_WIDTH +: COL_WIDTH] <=
                    b_wdata_i[lane*COL_WIDTH +: COL_WIDTH];
            end
        end
    end

    // Read-valid, one cycle after each enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_rvalid_o <= 1'b0;
            b_rvalid_o <= 1'b0;
        end else begin
            a_rvalid_o <= a_en_i;
            b_rvalid_o <= b_en_i;
        end
    end

endmodule : tcm_ram

`default_nettype wire

//--- rtl/icb_bridge.sv
/*
 * Data port to peripheral command/response bus bridge
 */
`default_nettype none

module icb_bridge (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // Data port side
    input  wire logic                sel_i,
    input  wire logic                we_i,
    input  wire coreplex_pkg::be_t   be_i,
    input  wire coreplex_pkg::word_t addr_i,
    input  wire coreplex_pkg::word_t wdata_i,
    output logic                     gnt_o,
    output logic                     rvalid_o,
    output coreplex_pkg::word_t      rdata_o,

    // Peripheral command channel
    output logic                     pd_cmd_valid_o,
    input  wire logic                pd_cmd_ready_i,
    output logic                     pd_cmd_read_o,
    output coreplex_pkg::word_t      pd_cmd_addr_o,
    output coreplex_pkg::word_t      pd_cmd_wdata_o,
    output coreplex_pkg::be_t        pd_cmd_wmask_o,

    // Peripheral response channel, always accepted
    input  wire logic                pd_rsp_valid_i,
    input  wire coreplex_pkg::word_t pd_rsp_rdata_i
);

    // ----------------------------------------
    // Command
    // ----------------------------------------

    // Command is offered as long as the request is held
    assign pd_cmd_valid_o = sel_i;
    assign pd_cmd_read_o  = ~we_i;
    assign pd_cmd_addr_o  = addr_i;
    assign pd_cmd_wdata_o = wdata_i;
    assign pd_cmd_wmask_o = be_i;

    // Grant on the transfer cycle only
    assign gnt_o = pd_cmd_valid_o & pd_cmd_ready_i;

    // ----------------------------------------
    // Response
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= pd_rsp_valid_i;
        end
    end

    // Payload captured with the response strobe
    always_ff @(posedge clk) begin
        if (pd_rsp_valid_i) begin
            rdata_o <= pd_rsp_rdata_i;
        end
    end

endmodule : icb_bridge

`default_nettype wire

//--- rtl/coreplex_fabric.sv
/*
 * Coreplex memory fabric top, decoder with TCM and peripheral bridge
 */
`default_nettype none

module coreplex_fabric (
    input  wire logic                clk,
    input  wire logic                rst_n,

    // Instruction port
    input  wire logic                instr_req_i,
    input  wire coreplex_pkg::word_t instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output coreplex_pkg::word_t      instr_rdata_o,

    // Data port
    input  wire logic                data_req_i,
    input  wire logic                data_we_i,
    input  wire coreplex_pkg::be_t   data_be_i,
    input  wire coreplex_pkg::word_t data_addr_i,
    input  wire coreplex_pkg::word_t data_wdata_i,
    output logic                     data_gnt_o,
    output logic                     data_rvalid_o,
    output coreplex_pkg::word_t      data_rdata_o,

    // Data peripheral bus
    output logic                     pd_cmd_valid_o,
    input  wire logic                pd_cmd_ready_i,
    output logic                     pd_cmd_read_o,
    output coreplex_pkg::word_t      pd_cmd_addr_o,
    output coreplex_pkg::word_t      pd_cmd_wdata_o,
    output coreplex_pkg::be_t        pd_cmd_wmask_o,
    input  wire logic                pd_rsp_valid_i,
    input  wire coreplex_pkg::word_t pd_rsp_rdata_i
);

    import coreplex_pkg::*;

    // Target selects
    logic     tcm_instr_sel;
    logic     tcm_data_sel;
    logic     pd_sel;

    // TCM word indices
    tcm_idx_t tcm_instr_idx;
    tcm_idx_t tcm_data_idx;

    // Target responses
    logic     tcm_instr_rvalid;
    word_t    tcm_instr_rdata;
    logic     tcm_data_rvalid;
    word_t    tcm_data_rdata;
    logic     pd_gnt;
    logic     pd_rvalid;
    word_t    pd_rdata;

    assign tcm_instr_idx = instr_addr_i[TCM_AWIDTH-1:2];
    assign tcm_data_idx  = data_addr_i[TCM_AWIDTH-1:2];

    // ----------------------------------------
    // Decode and response merge
    // ----------------------------------------

    bus_decoder u_decoder (
        .instr_req_i        (instr_req_i),
        .instr_addr_i       (instr_addr_i),
        .data_req_i         (data_req_i),
        .data_addr_i        (data_addr_i),
        .tcm_instr_rvalid_i (tcm_instr_rvalid),
        .tcm_instr_rdata_i  (tcm_instr_rdata),
        .tcm_data_rvalid_i  (tcm_data_rvalid),
        .tcm_data_rdata_i   (tcm_data_rdata),
        .pd_gnt_i           (pd_gnt),
        .pd_rvalid_i        (pd_rvalid),
        .pd_rdata_i         (pd_rdata),
        .tcm_instr_sel_o    (tcm_instr_sel),
        .tcm_data_sel_o     (tcm_data_sel),
        .pd_sel_o           (pd_sel),
        .instr_gnt_o        (instr_gnt_o),
        .instr_rvalid_o     (instr_rvalid_o),
        .instr_rdata_o      (instr_rdata_o),
        .data_gnt_o         (data_gnt_o),
        .data_rvalid_o      (data_rvalid_o),
        .data_rdata_o       (data_rdata_o)
    );

    // ----------------------------------------
    // TCM, port A instr and port B data
    // ----------------------------------------

    tcm_ram u_tcm (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_en_i     (tcm_instr_sel),
        .a_idx_i    (tcm_instr_idx),
        .a_rdata_o  (tcm_instr_rdata),
        .a_rvalid_o (tcm_instr_rvalid),
        .b_en_i     (tcm_data_sel),
        .b_idx_i    (tcm_data_idx),
        .b_we_i     (data_we_i),
        .b_be_i     (data_be_i),
        .b_wdata_i  (data_wdata_i),
        .b_rdata_o  (tcm_data_rdata),
        .b_rvalid_o (tcm_data_rvalid)
    );

    // ----------------------------------------
    // Peripheral bridge
    // ----------------------------------------

    icb_bridge u_bridge (
        .clk            (clk),
        .rst_n          (rst_n),
        .sel_i          (pd_sel),
        .we_i           (data_we_i),
        .be_i           (data_be_i),
        .addr_i         (data_addr_i),
        .wdata_i        (data_wdata_i),
        .gnt_o          (pd_gnt),
        .rvalid_o       (pd_rvalid),
        .rdata_o        (pd_rdata),
        .pd_cmd_valid_o (pd_cmd_valid_o),
        .pd_cmd_ready_i (pd_cmd_ready_i),
        .pd_cmd_read_o  (pd_cmd_read_o),
        .pd_cmd_addr_o  (pd_cmd_addr_o),
        .pd_cmd_wdata_o (pd_cmd_wdata_o),
        .pd_cmd_wmask_o (pd_cmd_wmask_o),
        .pd_rsp_valid_i (pd_rsp_valid_i),
        .pd_rsp_rdata_i (pd_rsp_rdata_i)
    );

endmodule : coreplex_fabric

`default_nettype wire

//--- dv/coreplex_fabric_sva.sv
/*
 * Handshake assertions on the coreplex fabric and their bind
 */
`default_nettype none

module coreplex_fabric_sva (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                instr_gnt_i,
    input wire logic                instr_rvalid_i,
    input wire logic                data_req_i,
    input wire coreplex_pkg::word_t data_addr_i,
    input wire logic                data_gnt_i,
    input wire logic                data_rvalid_i,
    input wire logic                pd_cmd_valid_i
);

    import coreplex_pkg::*;

    // Region of the data address, from the address map
    logic data_in_tcm;
    logic data_in_pd;

    assign data_in_tcm = (data_addr_i >> TCM_AWIDTH) == (TCM_ADDR_BASE >> TCM_AWIDTH);
    assign data_in_pd  = (data_addr_i & ~PD_ADDR_MASK) == PD_ADDR_BASE;

    // ----------------------------------------
    // TCM latency
    // ----------------------------------------

    a_instr_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        instr_gnt_i |=> instr_rvalid_i)
        else $error("instr_rvalid_o missing one cycle after a TCM grant");

    a_data_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        (data_gnt_i && data_in_tcm) |=> data_rvalid_i)
        else $error("data_rvalid_o missing one cycle after a TCM grant");

    // ----------------------------------------
    // Decode rules
    // ----------------------------------------

    // Grant only for a mapped region
    a_gnt_selected: assert property (@(posedge clk) disable iff (!rst_n)
        data_gnt_i |-> (data_req_i && (data_in_tcm || data_in_pd)))
        else $error("data_gnt_o high without a request to a mapped region");

    a_cmd_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        pd_cmd_valid_i |-> (data_req_i && data_in_pd))
        else $error("pd_cmd_valid_o high without a peripheral data request");

endmodule : coreplex_fabric_sva

bind coreplex_fabric coreplex_fabric_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_gnt_i    (instr_gnt_o),
    .instr_rvalid_i (instr_rvalid_o),
    .data_req_i     (data_req_i),
    .data_addr_i    (data_addr_i),
    .data_gnt_i     (data_gnt_o),
    .data_rvalid_i  (data_rvalid_o),
    .pd_cmd_valid_i (pd_cmd_valid_o)
);

`default_nettype wire

//--- dv/tb_coreplex_fabric.sv
/*
 * Testbench for the coreplex memory fabric with stimulus file reader,
 * peripheral bus model, TCM reference model, compare tasks and timeout
 */
`default_nettype none

module tb_coreplex_fabric;

    import coreplex_pkg::*;

    localparam STIM_FILE = "dv/coreplex_stim.txt";
    localparam word_t PD_RDATA_KEY = 32'ha5a5_0000;
    localparam int UNMAPPED_WAIT = 10;
    localparam int DRIVE_DELAY = 5;

    // ----------------------------------------
    // DUT signals
    // ----------------------------------------

    logic  clk = 1'b0;
    logic  rst_n;
    logic  instr_req_i;
    word_t instr_addr_i;
    logic  instr_gnt_o;
    logic  instr_rvalid_o;
    word_t instr_rdata_o;
    logic  data_req_i;
    logic  data_we_i;
    be_t   data_be_i;
    word_t data_addr_i;
    word_t data_wdata_i;
    logic  data_gnt_o;
    logic  data_rvalid_o;
    word_t data_rdata_o;
    logic  pd_cmd_valid_o;
    logic  pd_cmd_ready_i;
    logic  pd_cmd_read_o;
    word_t pd_cmd_addr_o;
    word_t pd_cmd_wdata_o;
    be_t   pd_cmd_wmask_o;
    logic  pd_rsp_valid_i;
    word_t pd_rsp_rdata_i;

    // Operations from the stimulus file
    logic [7:0] q_port[$];
    logic [7:0] q_op[$];
    word_t      q_addr[$];
    word_t      q_wdata[$];
    be_t        q_be[$];
    word_t      q_exp[$];
    logic       q_gnt[$];

    // Expected TCM contents
    word_t tcm_model [TCM_DEPTH];

    logic [31:0] lfsr_state = 32'he50;
    int err_value = 0;
    int err_other = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    coreplex_fabric i_coreplex_fabric (.*);

    always #20 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | lfsr_state[0];
        end
    endtask

    function automatic logic is_tcm(input word_t a);
        return (a >> TCM_AWIDTH) == (TCM_ADDR_BASE >> TCM_AWIDTH);
    endfunction

    function automatic tcm_idx_t tcm_index(input word_t a);
        return a[TCM_AWIDTH-1:2];
    endfunction

    task automatic compare_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            err_value++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            err_value++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_be(input string name, input be_t act, input be_t exp);
        if (act !== exp) begin
            err_value++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // ----------------------------------------
    // Stimulus file
    // ----------------------------------------

    task automatic load_stimulus();
        int fd;
        int code;
        logic bad;
        logic [7:0] port_c;
        logic [7:0] op_c;
        word_t addr_v;
        word_t wdata_v;
        word_t exp_v;
        be_t be_v;
        logic gnt_v;
        logic [8*256-1:0] skip_buf;
        bad = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            err_other++;
            $display("Cannot open the stimulus file %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && !bad) begin
                code = $fscanf(fd, " %c", port_c);
                if (code == 1 && port_c == "#") begin
                    code = $fgets(skip_buf, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, " %c %h %h %h %h %h",
                                   op_c, addr_v, wdata_v, be_v, exp_v, gnt_v);
                    if (code != 6 || !((port_c == "D" && (op_c == "R" || op_c == "W"))
                                       || (port_c == "I" && op_c == "R"))) begin
                        bad = 1'b1;
                        err_other++;
                        $display("Malformed stimulus entry after %0d operations",
                                 q_port.size());
                    end else begin
                        q_port.push_back(port_c);
                        q_op.push_back(op_c);
                        q_addr.push_back(addr_v);
                        q_wdata.push_back(wdata_v);
                        q_be.push_back(be_v);
                        q_exp.push_back(exp_v);
                        q_gnt.push_back(gnt_v);
                    end
                end
            end
            $fclose(fd);
            if (q_port.size() == 0) begin
                err_other++;
                $display("The stimulus file holds no operations");
            end
        end
    endtask

    // ----------------------------------------
    // CPU-side operations
    // ----------------------------------------

    task automatic run_instr(input int k);
        word_t exp_model;
        // Snapshot before any data write in the same cycle
        exp_model = tcm_model[tcm_index(q_addr[k])];
        @(posedge clk);
        #DRIVE_DELAY;
        instr_req_i  = 1'b1;
        instr_addr_i = q_addr[k];
        if (!q_gnt[k]) begin
            repeat (UNMAPPED_WAIT) begin
                @(negedge clk);
                compare_bit("instr_gnt_o", instr_gnt_o, 1'b0);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            instr_req_i = 1'b0;
        end else begin
            @(negedge clk);
            compare_bit("instr_gnt_o", instr_gnt_o, 1'b1);
            @(posedge clk);
            #DRIVE_DELAY;
            instr_req_i = 1'b0;
            @(negedge clk);
            compare_bit("instr_rvalid_o", instr_rvalid_o, 1'b1);
            compare_word("instr_rdata_o", instr_rdata_o, q_exp[k]);
            compare_word("instr_rdata_o vs TCM model", instr_rdata_o, exp_model);
        end
    endtask

    // Command fields while the bus command is offered
    task automatic check_pd_cmd(input int k);
        compare_bit("pd_cmd_valid_o", pd_cmd_valid_o, 1'b1);
        compare_bit("pd_cmd_read_o", pd_cmd_read_o, q_op[k] != "W");
        compare_word("pd_cmd_addr_o", pd_cmd_addr_o, q_addr[k]);
        compare_word("pd_cmd_wdata_o", pd_cmd_wdata_o, q_wdata[k]);
        compare_be("pd_cmd_wmask_o", pd_cmd_wmask_o, q_be[k]);
        compare_bit("data_gnt_o", data_gnt_o, pd_cmd_ready_i);
    endtask

    task automatic run_data(input int k);
        logic tcm_hit;
        tcm_idx_t idx;
        word_t exp_model;
        tcm_hit = is_tcm(q_addr[k]);
        idx = tcm_index(q_addr[k]);
        exp_model = tcm_model[idx];
        @(posedge clk);
        #DRIVE_DELAY;
        data_req_i   = 1'b1;
        data_we_i    = (q_op[k] == "W");
        data_be_i    = q_be[k];
        data_addr_i  = q_addr[k];
        data_wdata_i = q_wdata[k];
        if (!q_gnt[k]) begin
            // Unmapped, expect a stall and then withdraw
            repeat (UNMAPPED_WAIT) begin
                @(negedge clk);
                compare_bit("data_gnt_o", data_gnt_o, 1'b0);
                compare_bit("pd_cmd_valid_o", pd_cmd_valid_o, 1'b0);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            data_req_i = 1'b0;
            data_we_i  = 1'b0;
        end else begin
            @(negedge clk);
            if (tcm_hit) begin
                compare_bit("data_gnt_o", data_gnt_o, 1'b1);
                if (q_op[k] == "W") begin
                    for (int lane = 0; lane < NB_COL; lane++) begin
                        if (q_be[k][lane]) begin
                            tcm_model[idx][lane*COL_WIDTH +: COL_WIDTH] =
                                q_wdata[k][lane*COL_WIDTH +: COL_WIDTH];
                        end
                    end
                end
            end else begin
                // Held until the peripheral raises ready
                while (!data_gnt_o) begin
                    check_pd_cmd(k);
                    @(negedge clk);
                end
                check_pd_cmd(k);
            end
            @(posedge clk);
            #DRIVE_DELAY;
            data_req_i = 1'b0;
            data_we_i  = 1'b0;
            @(negedge clk);
            if (!tcm_hit) begin
                while (!pd_rsp_valid_i) begin
                    compare_bit("data_rvalid_o", data_rvalid_o, 1'b0);
                    @(negedge clk);
                end
                @(negedge clk);
            end
            compare_bit("data_rvalid_o", data_rvalid_o, 1'b1);
            if (q_op[k] == "R") begin
                compare_word("data_rdata_o", data_rdata_o, q_exp[k]);
                if (tcm_hit) begin
                    compare_word("data_rdata_o vs TCM model", data_rdata_o, exp_model);
                end else begin
                    compare_word("data_rdata_o vs bus rule", data_rdata_o,
                                 q_addr[k] ^ PD_RDATA_KEY);
                end
            end
        end
    endtask

    // ----------------------------------------
    // Peripheral bus model
    // ----------------------------------------

    initial begin : periph_model
        int stall;
        int gap;
        word_t cmd_addr;
        pd_cmd_ready_i = 1'b0;
        pd_rsp_valid_i = 1'b0;
        pd_rsp_rdata_i = '0;
        @(posedge rst_n);
        forever begin
            draw_bits(2, stall);
            draw_bits(1, gap);
            pd_cmd_ready_i = (stall == 0);
            @(negedge clk);
            while (!pd_cmd_valid_o) begin
                @(negedge clk);
            end
            if (stall != 0) begin
                repeat (stall - 1) @(posedge clk);
                @(posedge clk);
                #DRIVE_DELAY;
                pd_cmd_ready_i = 1'b1;
                @(negedge clk);
            end
            // Transfer on the coming edge
            cmd_addr = pd_cmd_addr_o;
            @(posedge clk);
            #DRIVE_DELAY;
            pd_cmd_ready_i = 1'b0;
            if (gap != 0) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            pd_rsp_valid_i = 1'b1;
            pd_rsp_rdata_i = cmd_addr ^ PD_RDATA_KEY;
            @(posedge clk);
            #DRIVE_DELAY;
            pd_rsp_valid_i = 1'b0;
        end
    end

    // ----------------------------------------
    // Timeout
    // ----------------------------------------

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout, the run did not complete within %0d cycles", cycle_limit);
            $display("Errors: %0d value mismatches, %0d other failures",
                     err_value, err_other + 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin : main_seq
        int k;
        rst_n        = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        for (int i = 0; i < TCM_DEPTH; i++) begin
            tcm_model[i] = '0;
        end
        load_stimulus();
        cycle_limit = q_port.size() * 20 + 100;

        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        compare_bit("instr_rvalid_o", instr_rvalid_o, 1'b0);
        compare_bit("data_rvalid_o", data_rvalid_o, 1'b0);
        compare_bit("pd_cmd_valid_o", pd_cmd_valid_o, 1'b0);

        // I line followed by a D line shares one request cycle
        k = 0;
        while (k < q_port.size()) begin
            if (q_port[k] == "I" && k + 1 < q_port.size() && q_port[k+1] == "D") begin
                fork
                    run_instr(k);
                    run_data(k + 1);
                join
                k += 2;
            end else if (q_port[k] == "I") begin
                run_instr(k);
                k++;
            end else begin
                run_data(k);
                k++;
            end
        end

        repeat (2) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_coreplex_fabric

`default_nettype wire

//--- dv/coreplex_stim.txt
# port op addr wdata be expected expect_gnt, all numbers in hex
# An I line directly followed by a D line runs both in the same cycle
D R 80000000 00000000 f 00000000 1
D W 80000010 11223344 f 00000000 1
D R 80000010 00000000 f 11223344 1
D W 80000010 aabbccdd 5 00000000 1
D R 80000010 00000000 f 11bb33dd 1
D W 80000020 cafef00d f 00000000 1
D W 80000020 00990000 4 00000000 1
D R 80000020 00000000 f ca99f00d 1
I R 80000010 00000000 0 11bb33dd 1
I R 80000020 00000000 0 ca99f00d 1
I R 80000010 00000000 0 11bb33dd 1
D W 80000010 55667788 3 00000000 1
I R 80000010 00000000 0 11bb7788 1
D R 80000020 00000000 f ca99f00d 1
I R 80000020 00000000 0 ca99f00d 1
D W 80000020 00000011 1 00000000 1
D R 80000020 00000000 f ca99f011 1
D W 10000100 deadbeef f 00000000 1
D W 10000104 0000ab00 2 00000000 1
D R 10000200 00000000 f b5a50200 1
D R 1ffffffc 00000000 f ba5afffc 1
D R 80000010 00000000 f 11bb7788 1
D W 100000f0 12345678 8 00000000 1
D R 10000010 00000000 f b5a50010 1
D R 20000000 00000000 f 00000000 0
D W 00000000 0badf00d f 00000000 0
I R 80000400 00000000 0 00000000 0
I R 80000020 00000000 0 ca99f011 1

//--- all.f
rtl/coreplex_pkg.sv
rtl/bus_decoder.sv
rtl/tcm_ram.sv
rtl/icb_bridge.sv
rtl/coreplex_fabric.sv
dv/coreplex_fabric_sva.sv
dv/tb_coreplex_fabric.sv
